// File: adapter_cfg.svh
// Configuration macros: data width, hierarchy sizes, address widths, operand count

`ifndef ADAPTER_CFG_SVH
`define ADAPTER_CFG_SVH

////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////

// Operand and result width
`define ADAPTER_DATA_WIDTH 32

// Source operands per instruction
`define ADAPTER_NUM_RS 2

////////////////////////////////////////////////////////////
// Responder hierarchy
////////////////////////////////////////////////////////////

`define ADAPTER_NUM_HIER 3

// Responders on each level
`define ADAPTER_NUM_RSP_L0 4
`define ADAPTER_NUM_RSP_L1 2
`define ADAPTER_NUM_RSP_L2 2

`define ADAPTER_NUM_RSP_TOT (`ADAPTER_NUM_RSP_L0 + `ADAPTER_NUM_RSP_L1 + `ADAPTER_NUM_RSP_L2)

// Largest level, sets the index width
`define ADAPTER_MAX_NUM_RSP 4

// Level bits on top, index bits below
`define ADAPTER_HIER_ADDR_W $clog2(`ADAPTER_NUM_HIER)
`define ADAPTER_ACC_ADDR_W  $clog2(`ADAPTER_MAX_NUM_RSP)
`define ADAPTER_ADDR_W      (`ADAPTER_HIER_ADDR_W + `ADAPTER_ACC_ADDR_W)

`endif

// File: adapter_x_pkg.sv
// Offload-side types: operand, instruction, register index and X request/response structs

`include "adapter_cfg.svh"

package adapter_x_pkg;

  ////////////////////////////////////////////////////////////
  // Basic words
  ////////////////////////////////////////////////////////////

  typedef logic [`ADAPTER_DATA_WIDTH-1:0] data_t;
  typedef logic [31:0]                    instr_t;
  typedef logic [4:0]                     reg_idx_t;

  // One flag per source operand
  typedef logic [`ADAPTER_NUM_RS-1:0] rs_mask_t;

  ////////////////////////////////////////////////////////////
  // Core to adapter
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                             q_valid;
    instr_t                           instr;
    data_t [`ADAPTER_NUM_RS-1:0]      rs;
    rs_mask_t                         rs_valid;
    logic                             rd_clean;
    logic                             p_ready;
  } x_req_t;

  // Adapter to core, handshake plus result channel
  typedef struct packed {
    logic     q_ready;
    logic     accept;
    logic     writeback;
    logic     p_valid;
    data_t    p_data;
    logic     p_error;
    reg_idx_t p_rd;
  } x_rsp_t;

endpackage

// File: adapter_c_pkg.sv
// Accelerator-side types: address, hart id, C request/response and predecoder structs

`include "adapter_cfg.svh"

package adapter_c_pkg;

  import adapter_x_pkg::*;

  ////////////////////////////////////////////////////////////
  // Addressing
  ////////////////////////////////////////////////////////////

  typedef logic [`ADAPTER_HIER_ADDR_W-1:0] hier_addr_t;
  typedef logic [`ADAPTER_ACC_ADDR_W-1:0]  acc_idx_t;

  // Level in the upper bits, index in the lower
  typedef logic [`ADAPTER_ADDR_W-1:0] acc_addr_t;

  typedef logic [`ADAPTER_DATA_WIDTH-1:0] hart_id_t;

  ////////////////////////////////////////////////////////////
  // Interconnect channels
  ////////////////////////////////////////////////////////////

  // Payload of one offloaded instruction
  typedef struct packed {
    acc_addr_t                   addr;
    hart_id_t                    hart_id;
    data_t [`ADAPTER_NUM_RS-1:0] rs;
    instr_t                      instr;
  } c_req_chan_t;

  typedef struct packed {
    logic        q_valid;
    c_req_chan_t q;
    logic        p_ready;
  } c_req_t;

  typedef struct packed {
    logic     q_ready;
    logic     p_valid;
    data_t    p_data;
    logic     p_error;
    reg_idx_t p_rd;
    hart_id_t p_hart_id;
  } c_rsp_t;

  ////////////////////////////////////////////////////////////
  // Predecoders
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    instr_t instr;
  } prd_req_t;

  typedef struct packed {
    logic     accept;
    rs_mask_t use_rs;
    logic     writeback;
  } prd_rsp_t;

endpackage

// File: prd_addr_enc.sv
// Predecoder accept encoder: per-level one-hot to level and index address

`include "adapter_cfg.svh"

module prd_addr_enc
  import adapter_c_pkg::*;
(
  input  logic [`ADAPTER_NUM_RSP_TOT-1:0] prd_accept_i,
  output acc_addr_t                       acc_addr_o,
  output logic                            any_accept_o
);

  localparam int unsigned NumHier = `ADAPTER_NUM_HIER;
  localparam int unsigned MaxRsp  = `ADAPTER_MAX_NUM_RSP;
  localparam int unsigned NumRsp [NumHier] = '{
    `ADAPTER_NUM_RSP_L0, `ADAPTER_NUM_RSP_L1, `ADAPTER_NUM_RSP_L2
  };

  // First responder of a level
  function automatic int unsigned rsp_base(int unsigned lvl);
    int unsigned sum;
    sum = 0;
    for (int unsigned k = 0; k < lvl; k++) begin
      sum += NumRsp[k];
    end
    return sum;
  endfunction

  function automatic acc_idx_t onehot_idx(logic [MaxRsp-1:0] onehot);
    acc_idx_t idx;
    idx = '0;
    for (int unsigned b = 0; b < MaxRsp; b++) begin
      if (onehot[b]) begin
        idx |= acc_idx_t'(b);
      end
    end
    return idx;
  endfunction

  logic [NumHier-1:0][MaxRsp-1:0] lvl_accept;
  acc_idx_t [NumHier-1:0]         lvl_idx;
  logic [NumHier-1:0]             lvl_hit;
  hier_addr_t                     hier_addr;
  acc_idx_t                       idx_lsb;

  // Slice each level, zero-extended to the widest level
  for (genvar l = 0; l < NumHier; l++) begin : gen_lvl
    localparam int unsigned Base = rsp_base(l);
    assign lvl_accept[l] = MaxRsp'(prd_accept_i[Base +: NumRsp[l]]);
    assign lvl_hit[l]    = |lvl_accept[l];
    assign lvl_idx[l]    = onehot_idx(lvl_accept[l]);
  end

  // Only one level is active, so ORing is enough
  always_comb begin
    hier_addr = '0;
    idx_lsb   = '0;
    for (int unsigned l = 0; l < NumHier; l++) begin
      if (lvl_hit[l]) begin
        hier_addr |= hier_addr_t'(l);
      end
      idx_lsb |= lvl_idx[l];
    end
  end

  assign acc_addr_o   = {hier_addr, idx_lsb};
  assign any_accept_o = |prd_accept_i;

  // At most one responder claims an instruction
  always_comb begin
    assert ($onehot0(prd_accept_i))
      else $error("prd_addr_enc: several predecoders accept, %b", prd_accept_i);
  end

endmodule

// File: offload_ctrl.sv
// Offload control: operand gating, mask merge, hazard check and acceptance

`include "adapter_cfg.svh"

module offload_ctrl
  import adapter_x_pkg::*;
  import adapter_c_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  x_req_t                              x_req_i,
  input  prd_rsp_t [`ADAPTER_NUM_RSP_TOT-1:0] prd_rsp_i,
  input  logic                                any_accept_i,
  input  acc_addr_t                           acc_addr_i,
  input  hart_id_t                            hart_id_i,
  input  logic                                fifo_ready_i,
  output logic                                fifo_valid_o,
  output c_req_chan_t                         fifo_req_o,
  output logic                                q_ready_o,
  output logic                                writeback_o
);

  localparam int unsigned NumRspTot = `ADAPTER_NUM_RSP_TOT;
  localparam int unsigned NumRs     = `ADAPTER_NUM_RS;

  rs_mask_t use_rs;
  logic     wb;
  logic     sources_valid;
  logic     rd_clean;

  ////////////////////////////////////////////////////////////
  // Merge of the accepting predecoder
  ////////////////////////////////////////////////////////////

  always_comb begin
    use_rs = '0;
    wb     = 1'b0;
    for (int unsigned i = 0; i < NumRspTot; i++) begin
      if (prd_rsp_i[i].accept) begin
        use_rs |= prd_rsp_i[i].use_rs;
        wb     |= prd_rsp_i[i].writeback;
      end
    end
  end

  // Request payload with unused operands zeroed
  always_comb begin
    fifo_req_o.addr    = acc_addr_i;
    fifo_req_o.hart_id = hart_id_i;
    fifo_req_o.instr   = x_req_i.instr;
    for (int unsigned j = 0; j < NumRs; j++) begin
      fifo_req_o.rs[j] = use_rs[j] ? x_req_i.rs[j] : '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Flow control
  ////////////////////////////////////////////////////////////

  // Every used source must be valid
  assign sources_valid = &(~use_rs | x_req_i.rs_valid);

  // WAW hazard on the destination
  assign rd_clean = ~wb | x_req_i.rd_clean;

  assign fifo_valid_o = x_req_i.q_valid & any_accept_i & sources_valid & rd_clean;

  // Rejected instructions are released at once
  assign q_ready_o   = ~any_accept_i | (sources_valid & rd_clean & fifo_ready_i);
  assign writeback_o = wb;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // An offload only leaves with all operands present
  for (genvar i = 0; i < NumRspTot; i++) begin : gen_chk
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (x_req_i.q_valid && q_ready_o && prd_rsp_i[i].accept)
        |-> (((prd_rsp_i[i].use_rs & ~x_req_i.rs_valid) == '0) &&
             (!prd_rsp_i[i].writeback || x_req_i.rd_clean)))
      else $error("offload_ctrl: offload accepted with missing operands or dirty rd");
  end

  // Core keeps the request until it sees q_ready
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (x_req_i.q_valid && !q_ready_o) |=> (x_req_i.q_valid && $stable(x_req_i.instr)))
    else $error("offload_ctrl: q_valid or instr changed without q_ready");

endmodule

// File: c_req_fifo.sv
// One-entry fall-through buffer for outgoing C requests

`include "adapter_cfg.svh"

module c_req_fifo
  import adapter_c_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        valid_i,
  output logic        ready_o,
  input  c_req_chan_t data_i,
  output logic        valid_o,
  input  logic        ready_i,
  output c_req_chan_t data_o
);

  logic        full_q;
  c_req_chan_t data_q;
  logic        push;

  // Store only what the C side did not take this cycle
  assign push = valid_i & ~full_q & ~ready_i;

  ////////////////////////////////////////////////////////////
  // Occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      if (ready_i) begin
        full_q <= 1'b0;
      end
    end else if (push) begin
      full_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_q <= data_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // Empty buffer is transparent
  assign valid_o = full_q | valid_i;
  assign data_o  = full_q ? data_q : data_i;

  // No new entry while the stored one waits
  assign ready_o = ~full_q;

  // Stalled request must not change
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(data_o)))
    else $error("c_req_fifo: C request changed while stalled");

endmodule

// File: acc_adapter_top.sv
// Adapter top: encoder, offload control, C request buffer and result forwarding

`include "adapter_cfg.svh"

module acc_adapter_top
  import adapter_x_pkg::*;
  import adapter_c_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  hart_id_t                            hart_id_i,
  input  x_req_t                              x_req_i,
  output x_rsp_t                              x_rsp_o,
  output c_req_t                              c_req_o,
  input  c_rsp_t                              c_rsp_i,
  output prd_req_t [`ADAPTER_NUM_RSP_TOT-1:0] prd_req_o,
  input  prd_rsp_t [`ADAPTER_NUM_RSP_TOT-1:0] prd_rsp_i
);

  localparam int unsigned NumRspTot = `ADAPTER_NUM_RSP_TOT;

  logic [NumRspTot-1:0] prd_accept;
  acc_addr_t            acc_addr;
  logic                 any_accept;

  logic        fifo_valid;
  logic        fifo_ready;
  c_req_chan_t fifo_req;
  logic        q_ready;
  logic        writeback;

  logic        c_valid;
  c_req_chan_t c_chan;

  // Every predecoder sees the same instruction
  for (genvar i = 0; i < NumRspTot; i++) begin : gen_prd
    assign prd_req_o[i].instr = x_req_i.instr;
    assign prd_accept[i]      = prd_rsp_i[i].accept;
  end

  prd_addr_enc u_prd_addr_enc (
    .prd_accept_i ( prd_accept ),
    .acc_addr_o   ( acc_addr   ),
    .any_accept_o ( any_accept )
  );

  offload_ctrl u_offload_ctrl (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .x_req_i      ( x_req_i    ),
    .prd_rsp_i    ( prd_rsp_i  ),
    .any_accept_i ( any_accept ),
    .acc_addr_i   ( acc_addr   ),
    .hart_id_i    ( hart_id_i  ),
    .fifo_ready_i ( fifo_ready ),
    .fifo_valid_o ( fifo_valid ),
    .fifo_req_o   ( fifo_req   ),
    .q_ready_o    ( q_ready    ),
    .writeback_o  ( writeback  )
  );

  c_req_fifo u_c_req_fifo (
    .clk_i    ( clk_i           ),
    .arst_n_i ( arst_n_i        ),
    .valid_i  ( fifo_valid      ),
    .ready_o  ( fifo_ready      ),
    .data_i   ( fifo_req        ),
    .valid_o  ( c_valid         ),
    .ready_i  ( c_rsp_i.q_ready ),
    .data_o   ( c_chan          )
  );

  ////////////////////////////////////////////////////////////
  // Port assembly
  ////////////////////////////////////////////////////////////

  always_comb begin
    c_req_o.q_valid = c_valid;
    c_req_o.q       = c_chan;
    c_req_o.p_ready = x_req_i.p_ready;
  end

  // Result channel passes straight through
  always_comb begin
    x_rsp_o.q_ready   = q_ready;
    x_rsp_o.accept    = any_accept;
    x_rsp_o.writeback = writeback;
    x_rsp_o.p_valid   = c_rsp_i.p_valid;
    x_rsp_o.p_data    = c_rsp_i.p_data;
    x_rsp_o.p_error   = c_rsp_i.p_error;
    x_rsp_o.p_rd      = c_rsp_i.p_rd;
  end

endmodule

// File: tb_acc_adapter.sv
// Testbench for the offload adapter: predecoder model, reference model, checker and watchdog

`include "adapter_cfg.svh"

module tb_acc_adapter
  import adapter_x_pkg::*;
  import adapter_c_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumRspTot = `ADAPTER_NUM_RSP_TOT;
  localparam int RandTxn   = 20;
  // Directed plus random offloads for the watchdog
  localparam int NumTxn    = 45;

  logic                     clk;
  logic                     arst_n;
  hart_id_t                 hart_id;
  x_req_t                   x_req;
  x_rsp_t                   x_rsp;
  c_req_t                   c_req;
  c_rsp_t                   c_rsp;
  prd_req_t [NumRspTot-1:0] prd_req;
  prd_rsp_t [NumRspTot-1:0] prd_rsp;

  integer      seed;
  c_req_chan_t exp_q[$];
  c_req_chan_t exp_head;
  logic [31:0] draw;
  int          cycles;
  int          rsp;
  rs_mask_t    use_rs;
  logic        wb;

  acc_adapter_top dut (
    .clk_i     ( clk     ),
    .arst_n_i  ( arst_n  ),
    .hart_id_i ( hart_id ),
    .x_req_i   ( x_req   ),
    .x_rsp_o   ( x_rsp   ),
    .c_req_o   ( c_req   ),
    .c_rsp_i   ( c_rsp   ),
    .prd_req_o ( prd_req ),
    .prd_rsp_i ( prd_rsp )
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference model and reporting
  ////////////////////////////////////////////////////////////

  function automatic c_req_chan_t exp_c_req(input int rsp_id, input rs_mask_t use_mask,
                                            input instr_t instr, input data_t rs0,
                                            input data_t rs1, input hart_id_t hid);
    c_req_chan_t want;
    hier_addr_t  lvl;
    acc_idx_t    idx;
    // Levels are numbered in order and the index restarts at zero on each
    if (rsp_id < `ADAPTER_NUM_RSP_L0) begin
      lvl = 2'd0;
      idx = acc_idx_t'(rsp_id);
    end else if (rsp_id < `ADAPTER_NUM_RSP_L0 + `ADAPTER_NUM_RSP_L1) begin
      lvl = 2'd1;
      idx = acc_idx_t'(rsp_id - `ADAPTER_NUM_RSP_L0);
    end else begin
      lvl = 2'd2;
      idx = acc_idx_t'(rsp_id - `ADAPTER_NUM_RSP_L0 - `ADAPTER_NUM_RSP_L1);
    end
    want.addr    = {lvl, idx};
    want.hart_id = hid;
    want.rs[0]   = use_mask[0] ? rs0 : '0;
    want.rs[1]   = use_mask[1] ? rs1 : '0;
    want.instr   = instr;
    return want;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    assert (got === want)
      else fail_run($sformatf("[ERROR] %0t %s: got %b, expected %b", $time, name, got, want));
  endtask

  task automatic check_word(input string name, input data_t got, input data_t want);
    assert (got === want)
      else fail_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, want));
  endtask

  task automatic check_req(input string name, input c_req_chan_t got, input c_req_chan_t want);
    assert (got === want)
      else fail_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, want));
  endtask

  ////////////////////////////////////////////////////////////
  // Predecoder model and offload driver
  ////////////////////////////////////////////////////////////

  // Non-accepting predecoders answer with junk masks
  task automatic drive_prd(input int rsp_id, input rs_mask_t use_mask, input logic wb_bit);
    logic [31:0] junk;
    for (int i = 0; i < NumRspTot; i++) begin
      junk = $random(seed);
      prd_rsp[i].accept    = 1'b0;
      prd_rsp[i].use_rs    = junk[1:0];
      prd_rsp[i].writeback = junk[2];
    end
    if (rsp_id >= 0) begin
      prd_rsp[rsp_id].accept    = 1'b1;
      prd_rsp[rsp_id].use_rs    = use_mask;
      prd_rsp[rsp_id].writeback = wb_bit;
    end
  endtask

  task automatic pick_prd(output int rsp_id, output rs_mask_t use_mask, output logic wb_bit);
    logic [31:0] roll;
    roll = $random(seed);
    // Nine outcomes where zero means no responder
    rsp_id = int'(roll % 32'd9) - 1;
    roll = $random(seed);
    use_mask = roll[1:0];
    wb_bit   = roll[2];
  endtask

  task automatic start_offload(input int rsp_id, input rs_mask_t use_mask, input logic wb_bit,
                               input rs_mask_t rs_valid, input logic rd_clean);
    x_req.q_valid  = 1'b1;
    x_req.instr    = $random(seed);
    x_req.rs[0]    = $random(seed);
    x_req.rs[1]    = $random(seed);
    x_req.rs_valid = rs_valid;
    x_req.rd_clean = rd_clean;
    drive_prd(rsp_id, use_mask, wb_bit);
    if (rsp_id >= 0) begin
      exp_q.push_back(exp_c_req(rsp_id, use_mask, x_req.instr, x_req.rs[0], x_req.rs[1],
                                hart_id));
    end
  endtask

  // Wait for q_ready and check the response of the accepting cycle
  task automatic wait_accept(input logic exp_accept, input logic exp_wb, output int n_wait);
    n_wait = 0;
    @(negedge clk);
    while (!x_rsp.q_ready) begin
      n_wait++;
      assert (n_wait < 50) else fail_run("offload still not accepted after 50 cycles");
      @(negedge clk);
    end
    check_bit("x_rsp_o.accept", x_rsp.accept, exp_accept);
    check_bit("x_rsp_o.writeback", x_rsp.writeback, exp_wb);
    check_bit("c_req_o.q_valid", c_req.q_valid, exp_accept);
    for (int i = 0; i < NumRspTot; i++) begin
      check_word($sformatf("prd_req_o[%0d].instr", i), prd_req[i].instr, x_req.instr);
    end
    @(posedge clk);
    #2;
    x_req.q_valid = 1'b0;
    drive_prd(-1, 2'b00, 1'b0);
  endtask

  task automatic hold_stalled(input int n);
    repeat (n) begin
      @(negedge clk);
      check_bit("x_rsp_o.q_ready", x_rsp.q_ready, 1'b0);
      check_bit("c_req_o.q_valid", c_req.q_valid, 1'b0);
    end
    @(posedge clk);
    #2;
  endtask

  ////////////////////////////////////////////////////////////
  // C side checker and watchdog
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (arst_n && c_req.q_valid && c_rsp.q_ready) begin
      assert (exp_q.size() > 0) else fail_run("C request issued with no offload pending");
      exp_head = exp_q.pop_front();
      check_req("c_req_o.q", c_req.q, exp_head);
    end
  end

  initial begin
    #(NumTxn * 50 * 20);
    fail_run("watchdog expired before the tests finished");
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    $timeformat(-9, 0, " ns", 0);
    seed    = 32'hdcdb9f9b;
    arst_n  = 1'b0;
    x_req   = '0;
    c_rsp   = '0;
    prd_rsp = '0;
    hart_id = $random(seed);
    repeat (4) @(posedge clk);
    #2;
    arst_n = 1'b1;
    c_rsp.q_ready = 1'b1;

    // Every responder alone with the request leaving in the same cycle
    for (int r = 0; r < NumRspTot; r++) begin
      draw = $random(seed);
      start_offload(r, draw[1:0], draw[2], 2'b11, 1'b1);
      wait_accept(1'b1, draw[2], cycles);
      assert (cycles == 0 && exp_q.size() == 0)
        else fail_run($sformatf("responder %0d: C request not issued in the offload cycle", r));
    end

    // All four use masks
    for (int m = 0; m < 4; m++) begin
      start_offload(m + 2, rs_mask_t'(m), 1'b0, 2'b11, 1'b1);
      wait_accept(1'b1, 1'b0, cycles);
    end

    // Missing source and then dirty destination
    start_offload(5, 2'b10, 1'b0, 2'b01, 1'b1);
    hold_stalled(3);
    x_req.rs_valid = 2'b11;
    wait_accept(1'b1, 1'b0, cycles);
    start_offload(7, 2'b00, 1'b1, 2'b11, 1'b0);
    hold_stalled(3);
    x_req.rd_clean = 1'b1;
    wait_accept(1'b1, 1'b1, cycles);

    // Nobody accepts
    start_offload(-1, 2'b11, 1'b1, 2'b11, 1'b1);
    wait_accept(1'b0, 1'b0, cycles);
    assert (cycles == 0) else fail_run("rejected instruction was not released at once");

    // C side stalls with one request buffered and a second waiting
    c_rsp.q_ready = 1'b0;
    start_offload(1, 2'b11, 1'b0, 2'b11, 1'b1);
    wait_accept(1'b1, 1'b0, cycles);
    start_offload(4, 2'b01, 1'b1, 2'b11, 1'b1);
    repeat (3) begin
      @(negedge clk);
      check_bit("x_rsp_o.q_ready", x_rsp.q_ready, 1'b0);
      check_bit("c_req_o.q_valid", c_req.q_valid, 1'b1);
      check_req("c_req_o.q", c_req.q, exp_q[0]);
    end
    @(posedge clk);
    #2;
    c_rsp.q_ready = 1'b1;
    wait_accept(1'b1, 1'b1, cycles);

    // Result channel forwarding
    repeat (8) begin
      draw = $random(seed);
      c_rsp.p_valid   = draw[0];
      c_rsp.p_error   = draw[1];
      c_rsp.p_rd      = draw[6:2];
      c_rsp.p_hart_id = hart_id;
      c_rsp.p_data    = $random(seed);
      x_req.p_ready   = draw[7];
      @(negedge clk);
      check_bit("x_rsp_o.p_valid", x_rsp.p_valid, c_rsp.p_valid);
      check_bit("x_rsp_o.p_error", x_rsp.p_error, c_rsp.p_error);
      check_word("x_rsp_o.p_data", x_rsp.p_data, c_rsp.p_data);
      check_word("x_rsp_o.p_rd", data_t'(x_rsp.p_rd), data_t'(c_rsp.p_rd));
      check_bit("c_req_o.p_ready", c_req.p_ready, x_req.p_ready);
      @(posedge clk);
      #2;
    end

    for (int n = 0; n < RandTxn; n++) begin
      pick_prd(rsp, use_rs, wb);
      start_offload(rsp, use_rs, wb, 2'b11, 1'b1);
      wait_accept(rsp >= 0, wb && (rsp >= 0), cycles);
    end

    repeat (3) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("%0d C requests never arrived", exp_q.size());
      $display("Test failures found");
      $fatal(1, "missing C requests");
    end
  end

endmodule

// File: sources.f
+incdir+.
adapter_x_pkg.sv
adapter_c_pkg.sv
prd_addr_enc.sv
offload_ctrl.sv
c_req_fifo.sv
acc_adapter_top.sv
tb_acc_adapter.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_acc_adapter
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
